//--- list.f
+incdir+include
rtl/tile_pkg.sv
rtl/video_if.sv
rtl/vga_timing.sv
rtl/button_debounce.sv
rtl/tile_map_rom.sv
rtl/sprite_rom.sv
rtl/bitmap_gen.sv
rtl/scroll_video_top.sv
tb/scroll_video_tb.sv

//--- tb/scroll_video_tb.sv
`timescale 1ns/100ps
`include "tile_macros.svh"

module scroll_video_tb;
	import tile_pkg::*;

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int TILE = 1 << `TILE_SHIFT;
	localparam rgb_t SKY = `SKY_COLOR;
	localparam rgb_t SEE_THROUGH = `TRANSPARENT_COLOR;
	// First blanking line after the last visible pixels have left the pipeline
	localparam int BLANK_LINE = `V_VISIBLE + 1;
	localparam int LINE_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
	localparam int LONG_MIN = 24;
	localparam int GAP_MIN = 40;
	localparam int PRINT_LIMIT = 25;

	logic clk;
	logic reset;
	logic [1:0] btn;
	logic hsync;
	logic vsync;
	rgb_t rgb;

	int tb_h;
	int tb_v;
	int model_scroll;
	logic [31:0] lfsr_state;
	string test_name;
	bit timed_out;
	int rgb_errors;
	int sync_errors;
	int other_errors;

	// Expected outputs, three stages deep like the pixel path
	rgb_t exp_rgb [0:2];
	logic [2:0] exp_hs;
	logic [2:0] exp_vs;
	logic [2:0] exp_vis;
	logic [2:0] exp_valid;

	scroll_video_top scroll_video_top_inst (
		.clk(clk),
		.reset(reset),
		.btn(btn),
		.hsync(hsync),
		.vsync(vsync),
		.rgb(rgb)
	);

	always #2 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
		return value;
	endfunction

	// Color from the map and sprite bank rules
	function automatic rgb_t expected_pixel(input int h, input int v, input int scroll);
		int map_word;
		int tile;
		int bank_tile;
		int mult;
		int sprite_word;
		rgb_t value;
		if (h >= `H_VISIBLE || v >= `V_VISIBLE)
			return '0;
		map_word = scroll * `MAP_ROWS + (h / TILE) * `MAP_ROWS + v / TILE;
		tile = map_word % 32;
		if (tile == 0)
			return SKY;
		if (tile <= 16) begin
			mult = 7;
			bank_tile = tile - 1;
		end else begin
			mult = 13;
			bank_tile = tile - 17;
		end
		sprite_word = h % TILE + (v % TILE) * TILE + bank_tile * TILE * TILE;
		value = rgb_t'(sprite_word * mult);
		if (value[3:0] == 4'h0)
			value = SEE_THROUGH;
		return (value == SEE_THROUGH) ? SKY : value;
	endfunction

	function automatic logic in_window(input int n, input int first, input int width);
		return (n >= first) && (n < first + width);
	endfunction

	// Reference counters and expected value pipeline
	always @(posedge clk) begin
		if (reset) begin
			tb_h <= 0;
			tb_v <= 0;
			exp_valid <= '0;
		end else begin
			exp_rgb[0] <= expected_pixel(tb_h, tb_v, model_scroll);
			exp_rgb[1] <= exp_rgb[0];
			exp_rgb[2] <= exp_rgb[1];
			exp_hs <= {exp_hs[1:0], !in_window(tb_h, `H_VISIBLE + `H_FRONT, `H_SYNC)};
			exp_vs <= {exp_vs[1:0], !in_window(tb_v, `V_VISIBLE + `V_FRONT, `V_SYNC)};
			exp_vis <= {exp_vis[1:0], (tb_h < `H_VISIBLE) && (tb_v < `V_VISIBLE)};
			exp_valid <= {exp_valid[1:0], 1'b1};
			if (tb_h == H_TOTAL - 1) begin
				tb_h <= 0;
				tb_v <= (tb_v == V_TOTAL - 1) ? 0 : tb_v + 1;
			end else begin
				tb_h <= tb_h + 1;
			end
		end
	end

	task automatic report_mismatch(input string check, input int expected, input int actual);
		if (rgb_errors + sync_errors <= PRINT_LIMIT)
			$display("ERROR %s %s: expected %03h, actual %03h at %0t",
				test_name, check, expected, actual, $time);
	endtask

	// Shown as rgb followed by hsync and vsync in the two low bits
	a_idle_outputs: assert property (@(posedge clk) disable iff (reset)
		!exp_valid[2] |-> (rgb == '0) && hsync && vsync)
	else begin
		sync_errors++;
		report_mismatch("idle_outputs", {12'h000, 2'b11},
			{$sampled(rgb), $sampled(hsync), $sampled(vsync)});
	end

	a_pixel: assert property (@(posedge clk) disable iff (reset)
		exp_valid[2] |-> rgb == exp_rgb[2])
	else begin
		rgb_errors++;
		report_mismatch("pixel", $sampled(exp_rgb[2]), $sampled(rgb));
	end

	a_black_border: assert property (@(posedge clk) disable iff (reset)
		exp_valid[2] && !exp_vis[2] |-> rgb == '0)
	else begin
		rgb_errors++;
		report_mismatch("black_border", 12'h000, $sampled(rgb));
	end

	a_hsync: assert property (@(posedge clk) disable iff (reset)
		exp_valid[2] |-> hsync == exp_hs[2])
	else begin
		sync_errors++;
		report_mismatch("hsync", $sampled(exp_hs[2]), $sampled(hsync));
	end

	a_vsync: assert property (@(posedge clk) disable iff (reset)
		exp_valid[2] |-> vsync == exp_vs[2])
	else begin
		sync_errors++;
		report_mismatch("vsync", $sampled(exp_vs[2]), $sampled(vsync));
	end

	task automatic wait_for_line(input int line);
		int cycles;
		cycles = 0;
		if (timed_out)
			return;
		while (!(tb_v == line && tb_h == 0) && cycles < LINE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= LINE_TIMEOUT) begin
			timed_out = 1'b1;
			other_errors++;
			$display("Timeout: line %0d not reached within %0d cycles", line, LINE_TIMEOUT);
		end
	endtask

	task automatic hold_button(input int index, input int high_cycles, input int low_cycles);
		btn[index] = 1'b1;
		repeat (high_cycles) @(negedge clk);
		btn[index] = 1'b0;
		repeat (low_cycles) @(negedge clk);
	endtask

	// Long enough to pass the debouncer, so the scroll moves by one
	task automatic press_long(input int index);
		int high_cycles;
		int low_cycles;
		high_cycles = LONG_MIN + take_bits(5);
		low_cycles = GAP_MIN + take_bits(4);
		hold_button(index, high_cycles, low_cycles);
		if (index == 0 && model_scroll < `SCROLL_MAX)
			model_scroll++;
		else if (index == 1 && model_scroll > 0)
			model_scroll--;
	endtask

	// Bounce shorter than the stability time
	task automatic press_short(input int index);
		int high_cycles;
		int low_cycles;
		high_cycles = 1 + take_bits(3);
		low_cycles = GAP_MIN + take_bits(4);
		hold_button(index, high_cycles, low_cycles);
	endtask

	task automatic check_in_blanking();
		if (!timed_out && tb_v <= `V_VISIBLE) begin
			other_errors++;
			$display("Press sequence for %s ran past vertical blanking", test_name);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		btn = 2'b00;
		lfsr_state = 32'h2cf8;
		model_scroll = 0;
		timed_out = 1'b0;
		rgb_errors = 0;
		sync_errors = 0;
		other_errors = 0;
		test_name = "reset_frame";
		repeat (10) @(negedge clk);
		reset = 1'b0;
		wait_for_line(BLANK_LINE);

		// Net two columns forward, bounces ignored
		test_name = "mixed_presses";
		repeat (3) press_long(0);
		press_short(0);
		press_long(1);
		press_short(1);
		check_in_blanking();
		wait_for_line(BLANK_LINE);

		test_name = "forward_saturation";
		repeat (85) press_long(0);
		press_short(1);
		check_in_blanking();
		wait_for_line(BLANK_LINE);

		test_name = "back_saturation";
		repeat (85) press_long(1);
		press_short(0);
		check_in_blanking();
		wait_for_line(BLANK_LINE);

		$display("Errors: rgb %0d, sync %0d, other %0d", rgb_errors, sync_errors, other_errors);
		if (rgb_errors + sync_errors + other_errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- rtl/scroll_video_top.sv
`timescale 1ns/100ps

module scroll_video_top (
	input logic clk,
	input logic reset,
	input logic [1:0] btn,
	output logic hsync,
	output logic vsync,
	output tile_pkg::rgb_t rgb
);
	// Matches the pixel pipeline depth in bitmap_gen
	localparam int SYNC_DELAY = 3;

	logic [1:0] btn_tick;
	logic [SYNC_DELAY-1:0] hsync_pipe;
	logic [SYNC_DELAY-1:0] vsync_pipe;

	video_if vid ();

	vga_timing timing_inst (
		.clk(clk),
		.reset(reset),
		.vid(vid.source)
	);

	// btn[0] scrolls forward, btn[1] scrolls back
	for (genvar i = 0; i < 2; i++) begin : g_debounce
		button_debounce debounce_inst (
			.clk(clk),
			.reset(reset),
			.sw(btn[i]),
			.level(),
			.tick(btn_tick[i])
		);
	end

	bitmap_gen bitmap_inst (
		.clk(clk),
		.reset(reset),
		.vid(vid.sink),
		.fwd_tick(btn_tick[0]),
		.back_tick(btn_tick[1]),
		.rgb(rgb)
	);

	// Syncs idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			hsync_pipe <= '1;
			vsync_pipe <= '1;
		end else begin
			hsync_pipe <= {hsync_pipe[SYNC_DELAY-2:0], vid.hsync};
			vsync_pipe <= {vsync_pipe[SYNC_DELAY-2:0], vid.vsync};
		end
	end

	assign hsync = hsync_pipe[SYNC_DELAY-1];
	assign vsync = vsync_pipe[SYNC_DELAY-1];

endmodule

//--- rtl/bitmap_gen.sv
`timescale 1ns/100ps
`include "tile_macros.svh"

module bitmap_gen (
	input logic clk,
	input logic reset,
	video_if.sink vid,
	input logic fwd_tick,
	input logic back_tick,
	output tile_pkg::rgb_t rgb
);
	import tile_pkg::*;

	localparam int OFFSET_BITS = `TILE_SHIFT;
	localparam tile_t BANK_A_LAST = tile_t'(16);
	localparam scroll_t SCROLL_LIMIT = scroll_t'(`SCROLL_MAX);

	scroll_t scroll;
	logic scroll_up;
	logic scroll_down;

	map_addr_t map_addr;
	sprite_addr_t sprite_addr;
	tile_t tile_1;
	tile_t tile_2;
	tile_t tile_index;
	logic [OFFSET_BITS-1:0] off_x_1;
	logic [OFFSET_BITS-1:0] off_y_1;
	logic on_1;
	logic on_2;

	rgb_t pixel_a;
	rgb_t pixel_b;
	rgb_t pixel;
	logic use_bank_b;
	logic is_sky;

	// Scroll column, saturating at both ends
	assign scroll_up = fwd_tick && (scroll < SCROLL_LIMIT);
	assign scroll_down = back_tick && (scroll != '0);

	always_ff @(posedge clk) begin
		if (reset)
			scroll <= '0;
		else if (scroll_up && !scroll_down)
			scroll <= scroll + 1'b1;
		else if (scroll_down && !scroll_up)
			scroll <= scroll - 1'b1;
	end

	// Map is stored column by column, 15 rows per column
	assign map_addr = map_addr_t'(scroll * `MAP_ROWS
		+ (vid.pix_x >> `TILE_SHIFT) * `MAP_ROWS
		+ (vid.pix_y >> `TILE_SHIFT));

	// Stage 1: map read, pixel offset follows
	tile_map_rom map_rom_inst (
		.clk(clk),
		.addr(map_addr),
		.data(tile_1)
	);

	always_ff @(posedge clk) begin
		off_x_1 <= vid.pix_x[OFFSET_BITS-1:0];
		off_y_1 <= vid.pix_y[OFFSET_BITS-1:0];
		tile_2 <= tile_1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			on_1 <= 1'b0;
			on_2 <= 1'b0;
		end else begin
			on_1 <= vid.video_on;
			on_2 <= on_1;
		end
	end

	// Tiles 17..31 wrap onto 0..14 once the top bit is dropped
	assign tile_index = tile_1 - 1'b1;
	assign sprite_addr = {tile_index[3:0], off_y_1, off_x_1};

	// Stage 2: both banks read the same address
	sprite_rom #(.MULT(7)) bank_a_inst (
		.clk(clk),
		.addr(sprite_addr),
		.data(pixel_a)
	);

	sprite_rom #(.MULT(13)) bank_b_inst (
		.clk(clk),
		.addr(sprite_addr),
		.data(pixel_b)
	);

	assign use_bank_b = (tile_2 > BANK_A_LAST);
	assign pixel = use_bank_b ? pixel_b : pixel_a;
	assign is_sky = (tile_2 == '0) || (pixel == `TRANSPARENT_COLOR);

	// Stage 3: output register, black outside the visible area
	always_ff @(posedge clk) begin
		if (reset)
			rgb <= '0;
		else if (!on_2)
			rgb <= '0;
		else if (is_sky)
			rgb <= `SKY_COLOR;
		else
			rgb <= pixel;
	end

	a_scroll_limit: assert property (
		@(posedge clk) disable iff (reset) scroll <= SCROLL_LIMIT
	);

endmodule

//--- rtl/sprite_rom.sv
`timescale 1ns/100ps
`include "tile_macros.svh"

module sprite_rom #(
	parameter int MULT = 7
) (
	input logic clk,
	input tile_pkg::sprite_addr_t addr,
	output tile_pkg::rgb_t data
);
	import tile_pkg::*;

	// 16 tiles of 32x32 pixels
	localparam int DEPTH = 1 << $bits(sprite_addr_t);

	rgb_t mem [0:DEPTH-1];

	// Pixel is the low 12 bits of addr*MULT
	initial begin
		rgb_t value;
		for (int i = 0; i < DEPTH; i++) begin
			value = rgb_t'(i * MULT);
			// Blue nibble of zero marks a see-through pixel
			if (value[3:0] == 4'h0)
				mem[i] = `TRANSPARENT_COLOR;
			else
				mem[i] = value;
		end
	end

	always_ff @(posedge clk)
		data <= mem[addr];

endmodule

//--- rtl/tile_map_rom.sv
`timescale 1ns/100ps

module tile_map_rom (
	input logic clk,
	input tile_pkg::map_addr_t addr,
	output tile_pkg::tile_t data
);
	import tile_pkg::*;

	// Covers the full scroll range plus one visible screen of columns
	localparam int DEPTH = 1 << $bits(map_addr_t);

	tile_t mem [0:DEPTH-1];

	// Tile index is the address mod 32, so every 32nd entry is sky
	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = tile_t'(i % 32);
	end

	always_ff @(posedge clk)
		data <= mem[addr];

endmodule

//--- rtl/button_debounce.sv
`timescale 1ns/100ps
`include "tile_macros.svh"

module button_debounce (
	input logic clk,
	input logic reset,
	input logic sw,
	output logic level,
	output logic tick
);
	import tile_pkg::*;

	db_state_t state;
	logic [`DB_COUNT_BITS-1:0] count;
	logic count_done;
	logic sw_meta;
	logic sw_sync;

	// Two flops in front of the FSM, the button is asynchronous
	always_ff @(posedge clk) begin
		if (reset) begin
			sw_meta <= 1'b0;
			sw_sync <= 1'b0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	assign count_done = &count;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DB_IDLE;
			count <= '0;
			tick <= 1'b0;
		end else begin
			tick <= 1'b0;
			case (state)
				DB_IDLE: begin
					count <= '0;
					if (sw_sync)
						state <= DB_WAIT_HIGH;
				end
				DB_WAIT_HIGH: begin
					if (!sw_sync) begin
						state <= DB_IDLE;
					end else if (count_done) begin
						state <= DB_HELD;
						tick <= 1'b1;
					end else begin
						count <= count + 1'b1;
					end
				end
				DB_HELD: begin
					count <= '0;
					if (!sw_sync)
						state <= DB_WAIT_LOW;
				end
				DB_WAIT_LOW: begin
					// A bounce back high returns to held without a new tick
					if (sw_sync)
						state <= DB_HELD;
					else if (count_done)
						state <= DB_IDLE;
					else
						count <= count + 1'b1;
				end
				default: state <= DB_IDLE;
			endcase
		end
	end

	assign level = (state == DB_HELD) || (state == DB_WAIT_LOW);

	a_tick_single: assert property (
		@(posedge clk) disable iff (reset) tick |=> !tick
	);

endmodule

//--- rtl/vga_timing.sv
`timescale 1ns/100ps
`include "tile_macros.svh"

module vga_timing (
	input logic clk,
	input logic reset,
	video_if.source vid
);
	import tile_pkg::*;

	localparam int H_TOTAL = `H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK;

	localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);
	localparam coord_t H_VIS = coord_t'(`H_VISIBLE);
	localparam coord_t V_VIS = coord_t'(`V_VISIBLE);
	localparam coord_t HS_FIRST = coord_t'(`H_VISIBLE + `H_FRONT);
	localparam coord_t HS_LAST = coord_t'(`H_VISIBLE + `H_FRONT + `H_SYNC - 1);
	localparam coord_t VS_FIRST = coord_t'(`V_VISIBLE + `V_FRONT);
	localparam coord_t VS_LAST = coord_t'(`V_VISIBLE + `V_FRONT + `V_SYNC - 1);

	coord_t h_cnt;
	coord_t v_cnt;
	coord_t h_next;
	coord_t v_next;
	logic h_end;
	logic v_end;

	assign h_end = (h_cnt == H_LAST);
	assign v_end = (v_cnt == V_LAST);

	always_comb begin
		h_next = h_end ? '0 : h_cnt + 1'b1;
		v_next = v_cnt;
		// Line counter steps once per wrap of the pixel counter
		if (h_end)
			v_next = v_end ? '0 : v_cnt + 1'b1;
	end

	// Flags are decoded from the next count so they line up with the coordinates
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
			vid.video_on <= 1'b1;
			vid.hsync <= 1'b1;
			vid.vsync <= 1'b1;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			vid.video_on <= (h_next < H_VIS) && (v_next < V_VIS);
			vid.hsync <= !((h_next >= HS_FIRST) && (h_next <= HS_LAST));
			vid.vsync <= !((v_next >= VS_FIRST) && (v_next <= VS_LAST));
		end
	end

	assign vid.pix_x = h_cnt;
	assign vid.pix_y = v_cnt;

	a_h_in_range: assert property (
		@(posedge clk) disable iff (reset) h_cnt <= H_LAST
	);

endmodule

//--- rtl/video_if.sv
`timescale 1ns/100ps

interface video_if;
	import tile_pkg::*;

	coord_t pix_x;
	coord_t pix_y;
	logic video_on;

	// Active low
	logic hsync;
	logic vsync;

	modport source (
		output pix_x, pix_y, video_on, hsync, vsync
	);

	modport sink (
		input pix_x, pix_y, video_on, hsync, vsync
	);

endinterface

//--- rtl/tile_pkg.sv
package tile_pkg;

	// Screen coordinate, wide enough for the 800 clock line
	typedef logic [9:0] coord_t;

	// 4 bits each of red, green, blue
	typedef logic [11:0] rgb_t;

	// 0 is empty, 1 to 16 bank A, 17 to 31 bank B
	typedef logic [4:0] tile_t;

	typedef logic [10:0] map_addr_t;

	// Tile within bank, row in tile, column in tile
	typedef logic [13:0] sprite_addr_t;

	typedef logic [7:0] scroll_t;

	typedef enum logic [1:0] {
		DB_IDLE,
		DB_WAIT_HIGH,
		DB_HELD,
		DB_WAIT_LOW
	} db_state_t;

endpackage

//--- include/tile_macros.svh
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Horizontal timing in pixel clocks
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// Tiles are 32x32 pixels
`define TILE_SHIFT 5
`define MAP_ROWS 15
`define SCROLL_MAX 80

// Kept small so a press settles in a few cycles
`define DB_COUNT_BITS 4

`define TRANSPARENT_COLOR 12'hF4F
`define SKY_COLOR 12'hE18

`endif
